/* tests/uart_trace.txt */
# command arguments in hex: send <byte> | raw <byte> <stop> | burst <count> <first byte>
# expect <byte> <frame_err> | drain_empty
send 55
send a3
expect 55 0
expect a3 0
send 00
send ff
expect 00 0
expect ff 0
raw 5a 0
expect 5a 1
raw c3 1
expect c3 0
burst 0a 3c
drain_empty
burst 08 81
drain_empty
send 7e
expect 7e 0

/* src.f */
verilog/uart_timing_pkg.sv
verilog/uart_frame_pkg.sv
verilog/uart_fifo_if.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
tests/uart_tb_assert.sv
tests/uart_tb.sv

/* Bender.yml */
package:
  name: uart_fifo

sources:
  - verilog/uart_timing_pkg.sv
  - verilog/uart_frame_pkg.sv
  - verilog/uart_fifo_if.sv
  - verilog/byte_fifo.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_top.sv
  - target: test
    files:
      - tests/uart_tb_assert.sv
      - tests/uart_tb.sv

/* tests/uart_tb.sv */
// Trace-driven testbench for the UART top level, run in loopback or with raw frames on rx_si.
`timescale 1ns/1ps

module uart_tb;

  localparam int cpb = 8;
  localparam int depth = 8;
  localparam int clk_period_ns = 8;
  localparam int frame_cycles = 10 * cpb;
  localparam int wait_limit = 2 * (depth + 4) * frame_cycles;

  logic clk;
  logic rst;
  logic wr_en;
  logic [7:0] wr_data;
  logic tx_full;
  logic rd_en;
  logic [7:0] rd_data;
  logic rd_frame_err;
  logic rx_empty;
  logic tx_so;
  logic tx_busy;
  logic tx_done;
  logic rx_si;
  logic rx_overrun;
  logic loop;
  logic raw_line;

  logic [127:0] cmd_q[$];
  logic [7:0] arg_a[$];
  logic [7:0] arg_b[$];
  logic [7:0] tx_exp[$];
  logic [7:0] burst_exp[$];
  logic [31:0] rng;
  longint limit_ns = 0;
  int bytes_sent = 0;
  int frames_seen = 0;
  int done_cnt = 0;
  int ovr_cnt = 0;
  int overrun_exp = 0;

  // loopback ties the line back to the transmitter, otherwise the testbench drives it.
  assign rx_si = loop ? tx_so : raw_line;

  uart_top #(
    .cycles_per_bit(cpb),
    .fifo_depth(depth)
  ) dut0 (
    .clk(clk),
    .rst(rst),
    .wr_en(wr_en),
    .wr_data(wr_data),
    .tx_full(tx_full),
    .rd_en(rd_en),
    .rd_data(rd_data),
    .rd_frame_err(rd_frame_err),
    .rx_empty(rx_empty),
    .tx_so(tx_so),
    .tx_busy(tx_busy),
    .tx_done(tx_done),
    .rx_si(rx_si),
    .rx_overrun(rx_overrun)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic give_up(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // wr_en stays high until a negedge shows room, so the next posedge takes the byte.
  task automatic write_byte(input logic [7:0] b);
    int t;
    t = 0;
    tx_exp.push_back(b);
    bytes_sent++;
    @(posedge clk);
    wr_en <= 1'b1;
    wr_data <= b;
    @(negedge clk);
    while (tx_full) begin
      t++;
      if (t > wait_limit) give_up("the transmit FIFO stayed full");
      else @(negedge clk);
    end
  endtask

  task automatic end_writes();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_word(input string name, input logic [7:0] b, input logic e);
    int t;
    t = 0;
    @(negedge clk);
    while (rx_empty) begin
      t++;
      if (t > wait_limit) give_up("no word reached the receive FIFO");
      else @(negedge clk);
    end
    check(name, b, rd_data);
    check({name, " frame_err"}, e, rd_frame_err);
    @(posedge clk);
    rd_en <= 1'b1;
    @(posedge clk);
    rd_en <= 1'b0;
  endtask

  task automatic send_raw(input logic [7:0] b, input logic stop);
    logic [9:0] bits;
    bits = {stop, b, 1'b0};
    @(posedge clk);
    loop <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      raw_line <= bits[i];
      repeat (cpb) @(posedge clk);
    end
    raw_line <= 1'b1;
    repeat (2 * cpb) @(posedge clk);
  endtask

  // the receiver pushes its last word before the last stop bit ends.
  task automatic wait_tx_quiet();
    int t;
    t = 0;
    @(negedge clk);
    while (done_cnt < bytes_sent) begin
      t++;
      if (t > wait_limit) give_up("the transmitter did not finish its frames");
      else @(negedge clk);
    end
    @(negedge clk);
    check("tx_busy after last frame", 0, tx_busy);
    check("frames seen on tx_so", bytes_sent, frames_seen);
    check("tx_done pulses", bytes_sent, done_cnt);
    check("rx_overrun pulses", overrun_exp, ovr_cnt);
  endtask

  task automatic drain_bursts();
    wait_tx_quiet();
    while (burst_exp.size() > 0) begin
      read_word("burst byte", burst_exp.pop_front(), 1'b0);
    end
    @(negedge clk);
    check("rx_empty after drain", 1, rx_empty);
  endtask

  always @(posedge clk) begin
    if (!rst && tx_done) done_cnt++;
    if (!rst && rx_overrun) ovr_cnt++;
  end

  // samples tx_so near each bit middle once the start edge has been seen.
  initial begin : frame_monitor
    logic prev;
    logic [7:0] exp_b;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (!rst && prev && !tx_so) begin
        if (tx_exp.size() == 0) begin
          give_up("a frame started on tx_so with no byte written");
        end else begin
          exp_b = tx_exp.pop_front();
          repeat (cpb / 2) @(negedge clk);
          check("start bit", 0, tx_so);
          check("tx_busy during frame", 1, tx_busy);
          for (int i = 0; i < 8; i++) begin
            repeat (cpb) @(negedge clk);
            check($sformatf("data bit %0d of %h", i, exp_b), exp_b[i], tx_so);
          end
          repeat (cpb) @(negedge clk);
          check("stop bit", 1, tx_so);
          check("tx_busy at stop bit", 1, tx_busy);
          frames_seen++;
        end
      end
      prev = tx_so;
    end
  end

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    give_up("the watchdog expired before the trace finished");
  end

  initial begin : run
    int fd;
    int n;
    logic [127:0] cmd;
    logic [8*128-1:0] rest;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] v;
    longint frames;
    clk = 1'b0;
    rst = 1'b1;
    wr_en = 1'b0;
    wr_data = 8'h00;
    rd_en = 1'b0;
    raw_line = 1'b1;
    loop = 1'b1;
    rng = 32'h7337_544e;
    frames = 0;
    fd = $fopen("tests/uart_trace.txt", "r");
    if (fd == 0) give_up("cannot open tests/uart_trace.txt");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      a = 8'h00;
      b = 8'h00;
      if (cmd == "#") begin
        n = $fgets(rest, fd);
      end else begin
        if (cmd == "send") begin
          n = $fscanf(fd, "%h", a);
          if (n != 1) give_up("a send line in the trace has no byte");
        end else if (cmd != "drain_empty") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2) give_up("a trace line is missing one of its two arguments");
        end
        cmd_q.push_back(cmd);
        arg_a.push_back(a);
        arg_b.push_back(b);
        frames += (cmd == "burst") ? a : 1;
      end
    end
    $fclose(fd);
    // twelve bit times per frame, doubled, with room for reset and settling.
    limit_ns = 2 * frames * 12 * cpb * clk_period_ns + 20 * frame_cycles * clk_period_ns;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("tx_so after reset", 1, tx_so);
    check("tx_busy after reset", 0, tx_busy);
    check("tx_done after reset", 0, tx_done);
    check("rx_empty after reset", 1, rx_empty);
    check("tx_full after reset", 0, tx_full);
    check("rx_overrun after reset", 0, rx_overrun);

    foreach (cmd_q[k]) begin
      if (cmd_q[k] == "send") begin
        @(posedge clk);
        loop <= 1'b1;
        write_byte(arg_a[k]);
        end_writes();
      end else if (cmd_q[k] == "raw") begin
        send_raw(arg_a[k], arg_b[k][0]);
      end else if (cmd_q[k] == "burst") begin
        @(posedge clk);
        loop <= 1'b1;
        v = arg_b[k];
        for (int j = 0; j < arg_a[k]; j++) begin
          if (j > 0) begin
            rng = xorshift32(rng);
            v = rng[7:0];
          end
          write_byte(v);
          if (burst_exp.size() < depth) burst_exp.push_back(v);
          else overrun_exp++;
        end
        end_writes();
      end else if (cmd_q[k] == "expect") begin
        read_word($sformatf("trace entry %0d expect", k), arg_a[k], arg_b[k][0]);
      end else if (cmd_q[k] == "drain_empty") begin
        drain_bursts();
      end else begin
        give_up("the trace file holds an unknown command");
      end
    end
    wait_tx_quiet();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tests/uart_tb_assert.sv */
// Concurrent assertions on the transmitter line and the FIFO flags, bound into the design.
`timescale 1ns/1ps

module uart_tb_assert
  import uart_frame_pkg::*;
#(
  parameter int bit_cycles = 8
) (
  input logic       clk,
  input logic       rst,
  input logic [2:0] state,
  input logic       tx_so,
  input logic       tx_done,
  input logic       full,
  input logic       empty
);

  idle_line_high: assert property (@(posedge clk) disable iff (rst)
    state == tx_idle |-> tx_so)
    else $error("tx_so low while the transmitter is idle");

  done_one_cycle: assert property (@(posedge clk) disable iff (rst)
    tx_done |=> !tx_done)
    else $error("tx_done held for more than one cycle");

  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(full && empty))
    else $error("FIFO full and empty at the same time");

  // the start bit holds low for a whole bit time.
  start_bit_low: assert property (@(posedge clk) disable iff (rst)
    $rose(state == tx_start) |-> (!tx_so) [*bit_cycles])
    else $error("start bit did not stay low for a full bit time");

endmodule

bind uart_tx uart_tb_assert #(.bit_cycles(cycles_per_bit)) tx_chk (
  .clk(clk), .rst(rst), .state(state), .tx_so(tx_so), .tx_done(tx_done),
  .full(1'b0), .empty(1'b0)
);

bind byte_fifo uart_tb_assert #(.bit_cycles(1)) fifo_chk (
  .clk(clk), .rst(rst), .state(3'd0), .tx_so(1'b1), .tx_done(1'b0),
  .full(q.full), .empty(q.empty)
);

/* verilog/uart_top.sv */
// UART top level with transmit and receive FIFOs, exposed to the host through plain ports.
`timescale 1ns/1ps

module uart_top
  import uart_timing_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int cycles_per_bit = default_cycles_per_bit,
  parameter int fifo_depth = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr_en,
  input  uart_byte_t wr_data,
  output logic       tx_full,
  input  logic       rd_en,
  output uart_byte_t rd_data,
  output logic       rd_frame_err,
  output logic       rx_empty,
  output logic       tx_so,
  output logic       tx_busy,
  output logic       tx_done,
  input  logic       rx_si,
  output logic       rx_overrun
);

  uart_fifo_if #(.payload_t(uart_byte_t)) tx_q ();
  uart_fifo_if #(.payload_t(rx_word_t)) rx_q ();

  // host write port onto the fill side of the transmit queue.
  assign tx_q.push = wr_en;
  assign tx_q.push_data = wr_data;
  assign tx_full = tx_q.full;

  // host read port onto the drain side of the receive queue.
  assign rx_q.pop = rd_en;
  assign rd_data = rx_q.pop_data.data;
  assign rd_frame_err = rx_q.pop_data.frame_err;
  assign rx_empty = rx_q.empty;

  byte_fifo #(
    .payload_t(uart_byte_t),
    .fifo_depth(fifo_depth)
  ) tx_fifo (
    .clk(clk),
    .rst(rst),
    .q(tx_q.store)
  );

  byte_fifo #(
    .payload_t(rx_word_t),
    .fifo_depth(fifo_depth)
  ) rx_fifo (
    .clk(clk),
    .rst(rst),
    .q(rx_q.store)
  );

  uart_tx #(.cycles_per_bit(cycles_per_bit)) tx0 (
    .clk(clk),
    .rst(rst),
    .src(tx_q.drain),
    .tx_so(tx_so),
    .tx_busy(tx_busy),
    .tx_done(tx_done)
  );

  uart_rx #(.cycles_per_bit(cycles_per_bit)) rx0 (
    .clk(clk),
    .rst(rst),
    .rx_si(rx_si),
    .dst(rx_q.fill),
    .rx_overrun(rx_overrun)
  );

endmodule

/* verilog/uart_rx.sv */
// UART receiver that samples 8N1 frames on rx_si and pushes each byte with its framing flag.
`timescale 1ns/1ps

module uart_rx
  import uart_timing_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int cycles_per_bit = default_cycles_per_bit
) (
  input  logic clk,
  input  logic rst,
  input  logic rx_si,
  uart_fifo_if.fill dst,
  output logic rx_overrun
);

  localparam int cnt_w = bit_cnt_w(cycles_per_bit);
  localparam int idx_w = $clog2(data_bits);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(cycles_per_bit - 1);
  localparam logic [cnt_w-1:0] half_max = cnt_w'(cycles_per_bit / 2 - 1);
  localparam logic [idx_w-1:0] last_bit = idx_w'(data_bits - 1);

  rx_state_t state;
  rx_state_t state_next;
  logic rx_meta;
  logic rx_sync;
  logic [cnt_w-1:0] cnt;
  logic [idx_w-1:0] bit_idx;
  uart_byte_t rx_shift;
  logic bit_end;
  logic stop_sample;

  assign bit_end = (cnt == cnt_max);
  assign stop_sample = (state == rx_stop) && bit_end;

  // the word goes out in the same cycle that the stop bit is sampled.
  assign dst.push = stop_sample && !dst.full;
  assign dst.push_data = '{frame_err: !rx_sync, data: rx_shift};

  // the line idles high, so the synchronizer comes out of reset high as well.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_si;
      rx_sync <= rx_meta;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      rx_idle: if (!rx_sync) state_next = rx_start;
      // a start bit that is already high again at its middle was a glitch.
      rx_start: if (cnt == half_max) state_next = rx_sync ? rx_idle : rx_data;
      rx_data: if (bit_end && bit_idx == last_bit) state_next = rx_stop;
      rx_stop: if (bit_end) state_next = rx_cleanup;
      rx_cleanup: if (rx_sync) state_next = rx_idle;
      default: state_next = rx_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      cnt <= '0;
      bit_idx <= '0;
      rx_overrun <= 1'b0;
    end else begin
      state <= state_next;
      rx_overrun <= stop_sample && dst.full;
      if (state == rx_idle || state == rx_cleanup) begin
        cnt <= '0;
        bit_idx <= '0;
      end else if ((state == rx_start && cnt == half_max) || bit_end) begin
        cnt <= '0;
        if (state == rx_data) begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // bits arrive LSB first, so each new one enters at the top.
  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end) begin
      rx_shift <= {rx_sync, rx_shift[data_bits-1:1]};
    end
  end

endmodule

/* verilog/uart_tx.sv */
// UART transmitter that pulls bytes from the transmit FIFO and sends 8N1 frames on tx_so.
`timescale 1ns/1ps

module uart_tx
  import uart_timing_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int cycles_per_bit = default_cycles_per_bit
) (
  input  logic clk,
  input  logic rst,
  uart_fifo_if.drain src,
  output logic tx_so,
  output logic tx_busy,
  output logic tx_done
);

  localparam int cnt_w = bit_cnt_w(cycles_per_bit);
  localparam int idx_w = $clog2(data_bits);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(cycles_per_bit - 1);
  localparam logic [idx_w-1:0] last_bit = idx_w'(data_bits - 1);

  tx_state_t state;
  tx_state_t state_next;
  logic [cnt_w-1:0] cnt;
  logic [idx_w-1:0] bit_idx;
  uart_byte_t tx_shift;
  logic bit_end;

  assign bit_end = (cnt == cnt_max);

  // a byte is taken as soon as the FSM is idle and the FIFO has one.
  assign src.pop = (state == tx_idle) && !src.empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tx_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      tx_idle: if (src.pop) state_next = tx_start;
      tx_start: if (bit_end) state_next = tx_data;
      tx_data: if (bit_end && bit_idx == last_bit) state_next = tx_stop;
      tx_stop: if (bit_end) state_next = tx_cleanup;
      tx_cleanup: state_next = tx_idle;
      default: state_next = tx_idle;
    endcase
  end

  // tx_so is loaded with the level of the bit that starts on the next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_so <= 1'b1;
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        tx_idle: begin
          tx_done <= 1'b0;
          cnt <= '0;
          bit_idx <= '0;
          if (src.pop) begin
            tx_so <= 1'b0;
            tx_busy <= 1'b1;
          end
        end
        tx_start: begin
          if (bit_end) begin
            cnt <= '0;
            tx_so <= tx_shift[0];
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_data: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == last_bit) begin
              bit_idx <= '0;
              tx_so <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_so <= tx_shift[1];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (bit_end) begin
            cnt <= '0;
            tx_done <= 1'b1;
            tx_busy <= 1'b0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_cleanup: tx_done <= 1'b0;
        default: begin
          tx_so <= 1'b1;
          tx_done <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (src.pop) begin
      tx_shift <= src.pop_data;
    end else if (state == tx_data && bit_end) begin
      tx_shift <= tx_shift >> 1;
    end
  end

endmodule

/* verilog/byte_fifo.sv */
// Synchronous circular-buffer FIFO for any payload type, used for transmit bytes and receive words.
`timescale 1ns/1ps

module byte_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int fifo_depth = 8
) (
  input logic clk,
  input logic rst,
  uart_fifo_if.store q
);

  localparam int addr_w = $clog2(fifo_depth);

  payload_t mem [fifo_depth];

  // the extra top bit tells a full buffer from an empty one.
  logic [addr_w:0] wr_ptr;
  logic [addr_w:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign q.empty = (wr_ptr == rd_ptr);
  assign q.full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                  (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  // the head entry is always on pop_data.
  assign q.pop_data = mem[rd_ptr[addr_w-1:0]];

  // gating by the flags makes a push and pop when full a pop only, and when empty a push only.
  assign do_push = q.push && !q.full;
  assign do_pop = q.pop && !q.empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[addr_w-1:0]] <= q.push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

/* verilog/uart_fifo_if.sv */
// Fill and drain strobes of one FIFO, shared between the FIFO and its two neighbors.
`timescale 1ns/1ps

interface uart_fifo_if #(
  parameter type payload_t = logic [7:0]
) ();

  logic     push;
  payload_t push_data;
  logic     full;
  logic     pop;
  payload_t pop_data;
  logic     empty;

  // the producer side writes entries.
  modport fill (output push, output push_data, input full);

  // the consumer side takes the head entry; pop_data is valid while empty is low.
  modport drain (output pop, input pop_data, input empty);

  modport store (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output empty
  );

endinterface

/* verilog/uart_frame_pkg.sv */
// Frame-level types for the UART: the data byte, the receive FIFO word and the FSM states.
package uart_frame_pkg;

  // one byte as written by the host or seen on the line.
  typedef logic [7:0] uart_byte_t;

  // frame_err is set when the stop bit was sampled low.
  typedef struct packed {
    logic       frame_err;
    uart_byte_t data;
  } rx_word_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_cleanup
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_cleanup
  } rx_state_t;

endpackage

/* verilog/uart_timing_pkg.sv */
// Bit-timing constants and counter sizing shared by the UART transmitter, receiver and top.
package uart_timing_pkg;

  // clocks per serial bit when the top level is not told otherwise.
  localparam int default_cycles_per_bit = 87;

  // every frame carries a fixed eight data bits, LSB first.
  localparam int data_bits = 8;

  // width of a counter that must reach cycles - 1.
  function automatic int bit_cnt_w(int cycles);
    int width;
    if (cycles > 1) begin
      width = $clog2(cycles);
    end else begin
      width = 1;
    end
    return width;
  endfunction

endpackage
